// File: rtl/nbr_pkg.sv
package nbr_pkg;

    // id and hop widths
    localparam int ID_W   = 16;      // node and cluster-head ids
    localparam int HOPS_W = 8;       // hop count to sink

    // table sizes
    localparam int NBR_DEPTH = 8;    // neighbor entries
    localparam int CH_DEPTH  = 4;    // known cluster heads

    // one extra bit so a count can hold the full depth
    localparam int NBR_IDX_W = $clog2(NBR_DEPTH + 1);  // 4 bits
    localparam int CH_IDX_W  = $clog2(CH_DEPTH + 1);   // 3 bits

    // packet type field, 3 bits wide like the radio header
    typedef enum logic [2:0] {
        PKT_HELLO     = 3'd0,
        PKT_CH_ADVERT = 3'd1
    } pkt_type_e;

    // received packet as seen by the updater
    typedef struct packed {
        logic [ID_W-1:0]   src_id;   // sender
        logic [HOPS_W-1:0] hops;     // sender's hop count
        pkt_type_e         pkt_type;
        logic [ID_W-1:0]   ch_id;    // advertised cluster head, adverts only
    } nbr_pkt_t;

    // one neighbor table row
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [HOPS_W-1:0] hops;
    } nbr_entry_t;

    typedef enum logic [1:0] {
        RES_NEW     = 2'd0,          // appended
        RES_UPDATED = 2'd1,          // hops overwritten
        RES_DROPPED = 2'd2           // table full
    } upd_result_e;

    // per-packet outcome, held from done to next start
    typedef struct packed {
        upd_result_e result;
        logic        ch_added;       // ch_id went into the known-CH list
    } upd_status_t;

    // which table the consumer port reads
    typedef enum logic {
        SEL_NBR = 1'b0,
        SEL_CH  = 1'b1
    } tbl_sel_e;

endpackage

// File: rtl/nbr_table_mem.sv
`timescale 1ns/1ps

// register array, one write port, two registered read ports
module nbr_table_mem #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 24,
    localparam int IW = $clog2(DEPTH + 1)   // index width, same as the count width
) (
    input  logic             clk,
    input  logic             wr_en,
    input  logic [IW-1:0]    wr_index,
    input  logic [WIDTH-1:0] wr_data,
    input  logic [IW-1:0]    search_index,  // fsm side
    input  logic [IW-1:0]    rd_index,      // consumer side
    output logic [WIDTH-1:0] search_data,
    output logic [WIDTH-1:0] rd_data
);

    localparam int AW = $clog2(DEPTH);                     // address bits into the array
    localparam logic [IW-1:0] DEPTH_IDX = IW'(DEPTH);      // first out of range index

    logic [WIDTH-1:0] mem [DEPTH];

    // out of range reads give zero instead of aliasing
    function automatic logic [WIDTH-1:0] read_at(input logic [IW-1:0] idx);
        read_at = (idx < DEPTH_IDX) ? mem[idx[AW-1:0]] : '0;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_index[AW-1:0]] <= wr_data;  // fsm never writes at or past depth
        end
    end

    // both ports sample before the write lands, so same index reads old data
    always_ff @(posedge clk) begin
        search_data <= read_at(search_index);
        rd_data     <= read_at(rd_index);
    end

endmodule

// File: rtl/nbr_update_fsm.sv
`timescale 1ns/1ps

// one packet at a time: latch, search neighbors, then known chs for adverts, report
module nbr_update_fsm
    import nbr_pkg::*;
(
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 start,
    input  nbr_pkt_t             pkt,
    input  nbr_entry_t           nbr_search_data,   // one cycle after nbr_search_index
    input  logic [ID_W-1:0]      ch_search_data,    // one cycle after ch_search_index
    output logic                 busy,
    output logic                 done,
    output upd_status_t          status,
    output logic [NBR_IDX_W-1:0] nbr_count,
    output logic [CH_IDX_W-1:0]  ch_count,
    output logic                 nbr_wr_en,
    output logic [NBR_IDX_W-1:0] nbr_wr_index,
    output nbr_entry_t           nbr_wr_data,
    output logic [NBR_IDX_W-1:0] nbr_search_index,
    output logic                 ch_wr_en,
    output logic [CH_IDX_W-1:0]  ch_wr_index,
    output logic [ID_W-1:0]      ch_wr_data,
    output logic [CH_IDX_W-1:0]  ch_search_index
);

    typedef enum logic [2:0] {
        S_IDLE,      // waiting for start
        S_NBR_CHK,   // n at end of table? else issue read
        S_NBR_CMP,   // compare returned id
        S_CH_CHK,    // k at end of list? else issue read
        S_CH_CMP     // compare returned ch id
    } state_e;

    localparam logic [NBR_IDX_W-1:0] NBR_FULL = NBR_IDX_W'(NBR_DEPTH);
    localparam logic [CH_IDX_W-1:0]  CH_FULL  = CH_IDX_W'(CH_DEPTH);

    state_e               state_q, state_d;
    nbr_pkt_t             pkt_q, pkt_d;          // latched packet
    logic [NBR_IDX_W-1:0] n_q, n_d;              // neighbor search index
    logic [CH_IDX_W-1:0]  k_q, k_d;              // ch search index
    logic [NBR_IDX_W-1:0] nbr_count_q;
    logic [CH_IDX_W-1:0]  ch_count_q;
    logic                 nbr_pend_q, nbr_pend_d; // neighbor appended, count bumps at done
    upd_status_t          status_q, status_d;
    logic                 done_q;
    logic                 nbr_end;               // neighbor phase finished this cycle
    logic                 finish;                // last cycle of the packet

    always_comb begin
        state_d    = state_q;
        pkt_d      = pkt_q;
        n_d        = n_q;
        k_d        = k_q;
        nbr_pend_d = nbr_pend_q;
        status_d   = status_q;
        nbr_end    = 1'b0;
        finish     = 1'b0;

        // write data is always the latched packet, only the enables move
        nbr_wr_en        = 1'b0;
        nbr_wr_index     = n_q;
        nbr_wr_data.id   = pkt_q.src_id;
        nbr_wr_data.hops = pkt_q.hops;
        ch_wr_en         = 1'b0;
        ch_wr_index      = k_q;
        ch_wr_data       = pkt_q.ch_id;

        case (state_q)
            S_IDLE: begin
                if (start) begin               // classify: take the packet
                    pkt_d             = pkt;
                    n_d               = '0;
                    k_d               = '0;
                    nbr_pend_d        = 1'b0;
                    status_d.ch_added = 1'b0;
                    state_d           = S_NBR_CHK;
                end
            end
            S_NBR_CHK: begin
                if (n_q == nbr_count_q) begin  // searched everything, not found
                    nbr_end = 1'b1;
                    if (nbr_count_q == NBR_FULL) begin
                        status_d.result = RES_DROPPED;
                    end else begin
                        nbr_wr_en       = 1'b1;   // append at n == count
                        nbr_pend_d      = 1'b1;
                        status_d.result = RES_NEW;
                    end
                end else begin
                    state_d = S_NBR_CMP;       // read of entry n goes out now
                end
            end
            S_NBR_CMP: begin
                if (nbr_search_data.id == pkt_q.src_id) begin
                    nbr_wr_en       = 1'b1;    // same row, new hops
                    status_d.result = RES_UPDATED;
                    nbr_end         = 1'b1;
                end else begin
                    n_d     = n_q + 1'b1;
                    state_d = S_NBR_CHK;
                end
            end
            S_CH_CHK: begin
                if (k_q == ch_count_q) begin   // ch id is new
                    finish = 1'b1;
                    if (ch_count_q != CH_FULL) begin
                        ch_wr_en          = 1'b1;
                        status_d.ch_added = 1'b1;
                    end
                end else begin
                    state_d = S_CH_CMP;
                end
            end
            S_CH_CMP: begin
                if (ch_search_data == pkt_q.ch_id) begin
                    finish = 1'b1;             // already known, nothing to add
                end else begin
                    k_d     = k_q + 1'b1;
                    state_d = S_CH_CHK;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase

        // adverts go on to the ch list, everything else is done
        if (nbr_end) begin
            if (pkt_q.pkt_type == PKT_CH_ADVERT) begin
                state_d = S_CH_CHK;
            end else begin
                finish = 1'b1;
            end
        end
        if (finish) begin
            state_d = S_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state_q     <= S_IDLE;
            n_q         <= '0;
            k_q         <= '0;
            nbr_count_q <= '0;
            ch_count_q  <= '0;
            nbr_pend_q  <= 1'b0;
            status_q    <= '{result: RES_NEW, ch_added: 1'b0};
            done_q      <= 1'b0;
        end else begin
            state_q    <= state_d;
            n_q        <= n_d;
            k_q        <= k_d;
            nbr_pend_q <= nbr_pend_d;
            status_q   <= status_d;
            done_q     <= finish;              // single pulse, state is back in idle
            if (finish) begin                  // counts move together with done
                nbr_count_q <= nbr_count_q + NBR_IDX_W'(nbr_pend_d);
            end
            if (ch_wr_en) begin                // ch append is always the finishing step
                ch_count_q <= ch_count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= pkt_d;
    end

    assign busy             = (state_q != S_IDLE);  // low again in the done cycle
    assign done             = done_q;
    assign status           = status_q;
    assign nbr_count        = nbr_count_q;
    assign ch_count         = ch_count_q;
    assign nbr_search_index = n_q;                  // held through the compare state
    assign ch_search_index  = k_q;

endmodule

// File: rtl/nbr_update_top.sv
`timescale 1ns/1ps

// neighbor table updater: control fsm plus neighbor and known-ch storage
module nbr_update_top
    import nbr_pkg::*;
(
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       start,
    input  nbr_pkt_t                   pkt,
    input  tbl_sel_e                   rd_sel,
    input  logic [NBR_IDX_W-1:0]       rd_index,
    output logic                       busy,
    output logic                       done,
    output upd_status_t                status,
    output logic [NBR_IDX_W-1:0]       nbr_count,
    output logic [CH_IDX_W-1:0]        ch_count,
    output logic [ID_W+HOPS_W-1:0]     rd_data
);

    localparam logic [CH_IDX_W-1:0] CH_OOR = CH_IDX_W'(CH_DEPTH);  // reads back zero

    // fsm to neighbor table
    logic                 nbr_wr_en;
    logic [NBR_IDX_W-1:0] nbr_wr_index;
    nbr_entry_t           nbr_wr_data;
    logic [NBR_IDX_W-1:0] nbr_search_index;
    nbr_entry_t           nbr_search_data;
    logic [ID_W+HOPS_W-1:0] nbr_rd_data;

    // fsm to ch list
    logic                 ch_wr_en;
    logic [CH_IDX_W-1:0]  ch_wr_index;
    logic [ID_W-1:0]      ch_wr_data;
    logic [CH_IDX_W-1:0]  ch_search_index;
    logic [ID_W-1:0]      ch_search_data;
    logic [CH_IDX_W-1:0]  ch_rd_index;
    logic [ID_W-1:0]      ch_rd_data;

    tbl_sel_e             rd_sel_q;        // lines up with the memory read latency

    nbr_update_fsm u_fsm (
        .clk              (clk),
        .nrst             (nrst),
        .start            (start),
        .pkt              (pkt),
        .nbr_search_data  (nbr_search_data),
        .ch_search_data   (ch_search_data),
        .busy             (busy),
        .done             (done),
        .status           (status),
        .nbr_count        (nbr_count),
        .ch_count         (ch_count),
        .nbr_wr_en        (nbr_wr_en),
        .nbr_wr_index     (nbr_wr_index),
        .nbr_wr_data      (nbr_wr_data),
        .nbr_search_index (nbr_search_index),
        .ch_wr_en         (ch_wr_en),
        .ch_wr_index      (ch_wr_index),
        .ch_wr_data       (ch_wr_data),
        .ch_search_index  (ch_search_index)
    );

    nbr_table_mem #(
        .DEPTH (NBR_DEPTH),
        .WIDTH ($bits(nbr_entry_t))
    ) u_nbr_mem (
        .clk          (clk),
        .wr_en        (nbr_wr_en),
        .wr_index     (nbr_wr_index),
        .wr_data      (nbr_wr_data),
        .search_index (nbr_search_index),
        .rd_index     (rd_index),
        .search_data  (nbr_search_data),
        .rd_data      (nbr_rd_data)
    );

    // clamp wide indices so they miss instead of wrapping onto a low entry
    assign ch_rd_index = (rd_index >= NBR_IDX_W'(CH_DEPTH)) ? CH_OOR
                                                           : rd_index[CH_IDX_W-1:0];

    nbr_table_mem #(
        .DEPTH (CH_DEPTH),
        .WIDTH (ID_W)
    ) u_ch_mem (
        .clk          (clk),
        .wr_en        (ch_wr_en),
        .wr_index     (ch_wr_index),
        .wr_data      (ch_wr_data),
        .search_index (ch_search_index),
        .rd_index     (ch_rd_index),
        .search_data  (ch_search_data),
        .rd_data      (ch_rd_data)
    );

    always_ff @(posedge clk) begin
        if (!nrst) begin
            rd_sel_q <= SEL_NBR;
        end else begin
            rd_sel_q <= rd_sel;
        end
    end

    // ch ids come out zero extended in the low bits
    assign rd_data = (rd_sel_q == SEL_CH) ? {{HOPS_W{1'b0}}, ch_rd_data} : nbr_rd_data;

endmodule

// File: dv/nbr_update_assertions.sv
`timescale 1ns/1ps

// control and count checks, bound onto the top level
module nbr_update_assertions
    import nbr_pkg::*;
(
    input logic                 clk,
    input logic                 nrst,
    input logic                 busy,
    input logic                 done,
    input logic [NBR_IDX_W-1:0] nbr_count,
    input logic [CH_IDX_W-1:0]  ch_count
);

    localparam logic [NBR_IDX_W-1:0] NBR_MAX = NBR_IDX_W'(NBR_DEPTH);

    int assert_errors = 0;   // failures so far, summed into the closing line

    // done never lasts two cycles
    done_pulse: assert property (@(posedge clk) disable iff (!nrst) done |=> !done)
        else begin
            $error("done stayed high for more than one cycle");
            assert_errors++;
        end

    // sync reset, so idle one edge later
    reset_idle: assert property (@(posedge clk) !nrst |=> (!busy && !done))
        else begin
            $error("busy or done high after reset");
            assert_errors++;
        end

    nbr_bound: assert property (@(posedge clk) disable iff (!nrst) nbr_count <= NBR_MAX)
        else begin
            $error("neighbor count above table depth");
            assert_errors++;
        end

    // counts step by one and only show up together with done
    nbr_step: assert property (@(posedge clk) disable iff (!nrst)
        (nbr_count != $past(nbr_count)) |-> (done && nbr_count == $past(nbr_count) + 1'b1))
        else begin
            $error("neighbor count moved outside done or by more than one");
            assert_errors++;
        end

    ch_step: assert property (@(posedge clk) disable iff (!nrst)
        (ch_count != $past(ch_count)) |-> (done && ch_count == $past(ch_count) + 1'b1))
        else begin
            $error("ch count moved outside done or by more than one");
            assert_errors++;
        end

endmodule

bind nbr_update_top nbr_update_assertions u_chk (
    .clk       (clk),
    .nrst      (nrst),
    .busy      (busy),
    .done      (done),
    .nbr_count (nbr_count),
    .ch_count  (ch_count)
);

// File: dv/nbr_update_tb.sv
`timescale 1ns/1ps

module nbr_update_tb
    import nbr_pkg::*;
();

    localparam int NUM_PKTS    = 24;                              // upper bound on packets
    localparam int PKT_CYCLES  = 2 * (NBR_DEPTH + CH_DEPTH) + 6;  // worst case latency
    localparam int READ_CYCLES = 2 * (NBR_DEPTH + CH_DEPTH) + 2;  // readback of both tables
    localparam int WATCHDOG_CYCLES = NUM_PKTS * (PKT_CYCLES + READ_CYCLES + 4) + 200;

    logic                   clk;
    logic                   nrst;
    logic                   start;
    nbr_pkt_t               pkt;
    tbl_sel_e               rd_sel;
    logic [NBR_IDX_W-1:0]   rd_index;
    logic                   busy;
    logic                   done;
    upd_status_t            status;
    logic [NBR_IDX_W-1:0]   nbr_count;
    logic [CH_IDX_W-1:0]    ch_count;
    logic [ID_W+HOPS_W-1:0] rd_data;

    // reference lists
    logic [ID_W-1:0]   ref_nbr_id [NBR_DEPTH];
    logic [HOPS_W-1:0] ref_nbr_hops [NBR_DEPTH];
    int                ref_nbr_cnt;
    logic [ID_W-1:0]   ref_ch [CH_DEPTH];
    int                ref_ch_cnt;

    logic [31:0] rng_state;
    int          errors;
    string       tname;   // current test name for fail lines

    nbr_update_top u_dut (
        .clk       (clk),
        .nrst      (nrst),
        .start     (start),
        .pkt       (pkt),
        .rd_sel    (rd_sel),
        .rd_index  (rd_index),
        .busy      (busy),
        .done      (done),
        .status    (status),
        .nbr_count (nbr_count),
        .ch_count  (ch_count),
        .rd_data   (rd_data)
    );

    always #10 clk = ~clk;   // 20 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic bit nbr_known(input logic [ID_W-1:0] id);
        for (int i = 0; i < ref_nbr_cnt; i++) begin
            if (ref_nbr_id[i] == id) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic bit ch_known(input logic [ID_W-1:0] id);
        for (int i = 0; i < ref_ch_cnt; i++) begin
            if (ref_ch[i] == id) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic nbr_pkt_t make_pkt(input pkt_type_e t, input logic [ID_W-1:0] src,
                                          input logic [HOPS_W-1:0] hops,
                                          input logic [ID_W-1:0] ch);
        nbr_pkt_t p;
        p.src_id   = src;
        p.hops     = hops;
        p.pkt_type = t;
        p.ch_id    = ch;
        return p;
    endfunction

    task automatic fresh_nbr_id(output logic [ID_W-1:0] id);
        do begin
            id = ID_W'(next_rand());
        end while (nbr_known(id));           // never seen by the table
    endtask

    task automatic fresh_ch_id(output logic [ID_W-1:0] id);
        do begin
            id = ID_W'(next_rand());
        end while (ch_known(id));
    endtask

    task automatic check_equal(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act) else begin
            errors++;
            $display("FAIL %s/%s: expected %0h, actual %0h", tname, what, exp, act);
        end
    endtask

    // add-or-update rules, then the ch list for adverts
    task automatic model_apply(input nbr_pkt_t p, output upd_result_e res,
                               output logic added);
        int hit;
        hit = -1;
        for (int i = 0; i < ref_nbr_cnt; i++) begin
            if (ref_nbr_id[i] == p.src_id) hit = i;
        end
        if (hit >= 0) begin
            ref_nbr_hops[hit] = p.hops;
            res = RES_UPDATED;
        end else if (ref_nbr_cnt == NBR_DEPTH) begin
            res = RES_DROPPED;                 // full but adverts still go on
        end else begin
            ref_nbr_id[ref_nbr_cnt]   = p.src_id;
            ref_nbr_hops[ref_nbr_cnt] = p.hops;
            ref_nbr_cnt++;
            res = RES_NEW;
        end
        added = 1'b0;
        if (p.pkt_type == PKT_CH_ADVERT && !ch_known(p.ch_id) && ref_ch_cnt < CH_DEPTH) begin
            ref_ch[ref_ch_cnt] = p.ch_id;
            ref_ch_cnt++;
            added = 1'b1;
        end
    endtask

    // one cycle read latency then a mid cycle sample
    task automatic read_back(input tbl_sel_e sel, input int idx,
                             output logic [ID_W+HOPS_W-1:0] data);
        @(posedge clk);
        rd_sel   <= sel;
        rd_index <= NBR_IDX_W'(idx);
        @(posedge clk);
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) @(negedge clk);        // returns in the done cycle
    endtask

    task automatic check_result(input nbr_pkt_t p);
        upd_result_e            exp_res;
        logic                   exp_added;
        logic [ID_W+HOPS_W-1:0] got;
        int                     i;
        model_apply(p, exp_res, exp_added);
        check_equal("result", 32'(exp_res), 32'(status.result));
        check_equal("ch_added", 32'(exp_added), 32'(status.ch_added));
        check_equal("nbr_count", 32'(ref_nbr_cnt), 32'(nbr_count));
        check_equal("ch_count", 32'(ref_ch_cnt), 32'(ch_count));
        for (i = 0; i < ref_nbr_cnt; i++) begin
            read_back(SEL_NBR, i, got);
            check_equal("nbr_entry", 32'({ref_nbr_id[i], ref_nbr_hops[i]}), 32'(got));
        end
        for (i = 0; i < ref_ch_cnt; i++) begin
            read_back(SEL_CH, i, got);
            check_equal("ch_entry", 32'({{HOPS_W{1'b0}}, ref_ch[i]}), 32'(got));  // zero ext
        end
    endtask

    task automatic run_packet(input nbr_pkt_t p);
        @(posedge clk);
        start <= 1'b1;
        pkt   <= p;
        @(posedge clk);                      // accepted on this edge
        start <= 1'b0;
        wait_done();
        check_result(p);
    endtask

    initial begin
        logic [ID_W-1:0] id_a;
        logic [ID_W-1:0] id_b;
        logic [ID_W-1:0] id_c;
        logic [ID_W-1:0] ch_a;
        logic [ID_W-1:0] ch_b;
        nbr_pkt_t        p_a;
        nbr_pkt_t        p_b;
        int              extra;

        clk         = 1'b0;
        nrst        = 1'b0;
        start       = 1'b0;
        pkt         = '0;
        rd_sel      = SEL_NBR;
        rd_index    = '0;
        rng_state   = 32'hcd3c_358a;
        errors      = 0;
        ref_nbr_cnt = 0;
        ref_ch_cnt  = 0;

        tname = "reset";
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_equal("busy", 32'd0, 32'(busy));
        check_equal("done", 32'd0, 32'(done));
        check_equal("nbr_count", 32'd0, 32'(nbr_count));
        check_equal("ch_count", 32'd0, 32'(ch_count));

        tname = "new_source";
        fresh_nbr_id(id_a);
        run_packet(make_pkt(PKT_HELLO, id_a, HOPS_W'(next_rand()), '0));

        tname = "update_hops";
        // id_a sits at index 0, inverted hops always differ from the stored ones
        run_packet(make_pkt(PKT_HELLO, id_a, ~ref_nbr_hops[0], '0));

        tname = "ch_advert";
        fresh_nbr_id(id_b);
        fresh_ch_id(ch_a);
        run_packet(make_pkt(PKT_CH_ADVERT, id_b, HOPS_W'(next_rand()), ch_a));
        tname = "ch_repeat";
        run_packet(make_pkt(PKT_CH_ADVERT, id_b, HOPS_W'(next_rand()), ch_a));
        tname = "hello_keeps_ch";
        fresh_ch_id(ch_b);                   // ch field set but a hello ignores it
        run_packet(make_pkt(PKT_HELLO, id_a, HOPS_W'(next_rand()), ch_b));
        tname = "ch_fill";
        for (int i = 0; i < CH_DEPTH; i++) begin   // last one finds the list full
            fresh_ch_id(ch_b);
            run_packet(make_pkt(PKT_CH_ADVERT, id_b, HOPS_W'(next_rand()), ch_b));
        end

        // second packet rides on start while the first is busy
        tname = "busy_start";
        fresh_nbr_id(id_c);
        do begin
            fresh_nbr_id(id_b);
        end while (id_b == id_c);
        p_a = make_pkt(PKT_HELLO, id_c, HOPS_W'(next_rand()), '0);
        p_b = make_pkt(PKT_HELLO, id_b, HOPS_W'(next_rand()), '0);
        @(posedge clk);
        start <= 1'b1;
        pkt   <= p_a;
        @(posedge clk);
        pkt   <= p_b;
        @(negedge clk);
        check_equal("busy", 32'd1, 32'(busy));
        repeat (2) @(posedge clk);
        start <= 1'b0;
        wait_done();
        extra = 0;
        repeat (PKT_CYCLES) begin
            @(negedge clk);
            if (done) extra++;
        end
        check_equal("extra_done", 32'd0, 32'(extra));
        check_result(p_a);

        tname = "nbr_fill";
        while (ref_nbr_cnt < NBR_DEPTH) begin
            fresh_nbr_id(id_b);
            run_packet(make_pkt(PKT_HELLO, id_b, HOPS_W'(next_rand()), '0));
        end
        tname = "nbr_full";
        fresh_nbr_id(id_b);
        run_packet(make_pkt(PKT_HELLO, id_b, HOPS_W'(next_rand()), '0));
        tname = "full_advert";
        fresh_nbr_id(id_b);
        run_packet(make_pkt(PKT_CH_ADVERT, id_b, HOPS_W'(next_rand()), ch_a));
        tname = "full_update";
        run_packet(make_pkt(PKT_HELLO, id_a, ~ref_nbr_hops[0], '0));

        $display("errors: %0d check failures, %0d assertion failures",
                 errors, u_dut.u_chk.assert_errors);
        if (errors == 0 && u_dut.u_chk.assert_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // bound by packet count times worst case latency plus readback
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: files.f
rtl/nbr_pkg.sv
rtl/nbr_table_mem.sv
rtl/nbr_update_fsm.sv
rtl/nbr_update_top.sv
dv/nbr_update_assertions.sv
dv/nbr_update_tb.sv

// File: run.sh
#!/bin/sh
# build and run the neighbor table updater testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module nbr_update_tb \
    -f files.f

# keep running after a bound assertion fires so the testbench can report it
out=$(./obj_dir/Vnbr_update_tb +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi
